//--- project.f
hw/if_pkg.sv
hw/if_fetch_unit.sv
hw/if_instr_fifo.sv
hw/if_id_register.sv
hw/if_stage.sv
verif/if_tb_memory.sv
verif/tb_if_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_if_stage
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_if_stage.sv
// Fetch stage testbench
`timescale 1ns/1ps

module tb_if_stage;

  localparam int BOOT_WORDS  = 16;
  localparam int REDIR_WORDS = 6;
  localparam int FLOW_WORDS  = 24;
  localparam int SHORT_WORDS = 8;
  localparam int HALT_CYCLES = 10;
  // Words accepted over all tests
  localparam int TOTAL_WORDS = BOOT_WORDS + 5 * REDIR_WORDS + 3 * FLOW_WORDS
                             + 4 * SHORT_WORDS;
  // A few cycles per word under stalls and back-pressure, plus redirects and halt
  localparam int CYCLE_LIMIT = 8 * TOTAL_WORDS + 20 * HALT_CYCLES + 400;

  logic                    clk;
  logic                    rst_n;
  if_pkg::if_ctrl_t        ctrl;
  if_pkg::pc_targets_t     targets;
  logic                    trigger_match;
  logic                    id_ready;
  logic                    stall_en;
  logic                    gnt;
  if_pkg::instr_bus_resp_t bus_resp;
  if_pkg::instr_bus_req_t  bus_req;
  logic                    if_valid;
  logic [31:0]             pc_if;
  if_pkg::if_id_pipe_t     if_id_pipe;
  logic                    if_busy;
  logic [31:0]             lfsr_q      = 32'h322a;
  int                      error_cnt   = 0;
  int                      cycle_cnt   = 0;
  // Granted fetches not yet answered
  int                      bus_pending = 0;

  if_stage DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_i          (ctrl),
    .targets_i       (targets),
    .trigger_match_i (trigger_match),
    .id_ready_i      (id_ready),
    .gnt_i           (gnt),
    .bus_resp_i      (bus_resp),
    .bus_req_o       (bus_req),
    .if_valid_o      (if_valid),
    .pc_if_o         (pc_if),
    .if_id_pipe_o    (if_id_pipe),
    .if_busy_o       (if_busy)
  );

  if_tb_memory u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall_en_i (stall_en),
    .bus_req_i  (bus_req),
    .gnt_o      (gnt),
    .bus_resp_o (bus_resp)
  );

  always #50 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // Redirect address from the PC mux rules
  function automatic logic [31:0] target_of(input if_pkg::pc_mux_e mux, input logic [4:0] idx);
    logic [31:0] base;
    // Trap base is the field followed by seven zero bits
    base = {7'b0, targets.mtvec_addr} << 7;
    case (mux)
      if_pkg::PC_JUMP:     return targets.jump_target & ~32'h3;
      if_pkg::PC_BRANCH:   return targets.branch_target & ~32'h3;
      if_pkg::PC_MRET:     return targets.mepc & ~32'h3;
      if_pkg::PC_TRAP_EXC: return base;
      if_pkg::PC_TRAP_IRQ: return base + (32'(idx) << 2);
      default:             return targets.boot_addr & ~32'h3;
    endcase
  endfunction

  // Register contents expected for the word at pc
  function automatic if_pkg::if_id_pipe_t expect_entry(input logic [31:0] pc, input logic trig);
    if_pkg::if_id_pipe_t e;
    e.instr_valid = 1'b1;
    e.instr       = {pc[31:2], pc[3:2]};
    e.pc          = pc;
    e.bus_err     = (pc[31:28] == 4'hE);
    // Only low bits 2'b11 mean a full-size word
    e.compressed  = (pc[3:2] != 2'b11);
    e.abort_op    = e.bus_err || trig;
    return e;
  endfunction

  task automatic check_pipe(input string name, input if_pkg::if_id_pipe_t exp,
                            input if_pkg::if_id_pipe_t got);
    if (got !== exp) begin
      error_cnt++;
      $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      error_cnt++;
      $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      error_cnt++;
      $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  // pc_set for one cycle with decode stalled, so no old word slips through
  task automatic redirect(input if_pkg::pc_mux_e mux, input logic [4:0] idx);
    ctrl.pc_set      <= 1'b1;
    ctrl.pc_mux      <= mux;
    ctrl.mtvec_index <= idx;
    id_ready         <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    ctrl.pc_set <= 1'b0;
  endtask

  // Accept n words from pc upward and check each one and the hold under stall
  task automatic collect(inout logic [31:0] pc, input int n, input bit rand_ready,
                         input bit trig);
    if_pkg::if_id_pipe_t exp;
    if_pkg::if_id_pipe_t last_exp;
    logic                ready;
    bit                  have_last;
    int                  got;
    have_last     = 1'b0;
    got           = 0;
    trigger_match <= trig;
    while (got < n) begin
      ready = rand_ready ? lfsr_step() : 1'b1;
      id_ready <= ready;
      @(posedge clk);
      @(negedge clk);
      if (ready) begin
        if (if_id_pipe.instr_valid) begin
          exp = expect_entry(pc, trig);
          check_pipe("if_id_pipe_o", exp, if_id_pipe);
          last_exp  = exp;
          have_last = 1'b1;
          pc        = pc + 32'd4;
          got++;
        end else begin
          last_exp.instr_valid = 1'b0;
        end
      end else if (have_last) begin
        check_pipe("if_id_pipe_o on stall", last_exp, if_id_pipe);
      end
    end
  endtask

  task automatic fetch_from(input if_pkg::pc_mux_e mux, input logic [4:0] idx, input int n,
                            input bit rand_ready, input bit trig, output logic [31:0] next_pc);
    logic [31:0] pc;
    pc = target_of(mux, idx);
    redirect(mux, idx);
    // New target on the bus right after the redirect edge
    check_addr("bus_req_o.addr", pc, bus_req.addr);
    collect(pc, n, rand_ready, trig);
    next_pc = pc;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_state();
    check_bit("bus_req_o.req", 1'b0, bus_req.req);
    check_addr("bus_req_o.addr", 32'h0, bus_req.addr);
    check_bit("if_valid_o", 1'b0, if_valid);
    check_bit("instr_valid", 1'b0, if_id_pipe.instr_valid);
    check_bit("if_busy_o", 1'b0, if_busy);
  endtask

  task automatic test_boot();
    logic [31:0] pc;
    fetch_from(if_pkg::PC_BOOT, 5'd0, BOOT_WORDS, 1'b0, 1'b0, pc);
  endtask

  task automatic test_redirects();
    logic [31:0] pc;
    // Random ready keeps old fetches in flight at each redirect
    fetch_from(if_pkg::PC_JUMP, 5'd0, REDIR_WORDS, 1'b1, 1'b0, pc);
    fetch_from(if_pkg::PC_BRANCH, 5'd0, REDIR_WORDS, 1'b1, 1'b0, pc);
    fetch_from(if_pkg::PC_MRET, 5'd0, REDIR_WORDS, 1'b1, 1'b0, pc);
    fetch_from(if_pkg::PC_TRAP_EXC, 5'd0, REDIR_WORDS, 1'b1, 1'b0, pc);
    fetch_from(if_pkg::PC_TRAP_IRQ, 5'd5, REDIR_WORDS, 1'b1, 1'b0, pc);
  endtask

  task automatic test_backpressure();
    logic [31:0] pc;
    fetch_from(if_pkg::PC_JUMP, 5'd0, FLOW_WORDS, 1'b1, 1'b0, pc);
  endtask

  task automatic test_stalls();
    logic [31:0] pc;
    stall_en <= 1'b1;
    fetch_from(if_pkg::PC_BRANCH, 5'd0, FLOW_WORDS, 1'b0, 1'b0, pc);
    collect(pc, FLOW_WORDS, 1'b1, 1'b0);
    stall_en <= 1'b0;
  endtask

  task automatic test_errors();
    logic [31:0] pc;
    targets.jump_target = 32'hE000_0040;
    fetch_from(if_pkg::PC_JUMP, 5'd0, SHORT_WORDS, 1'b0, 1'b0, pc);
    // Trigger alone marks the abort
    fetch_from(if_pkg::PC_BOOT, 5'd0, SHORT_WORDS, 1'b0, 1'b1, pc);
    trigger_match <= 1'b0;
  endtask

  task automatic test_halt();
    logic [31:0] pc;
    fetch_from(if_pkg::PC_MRET, 5'd0, SHORT_WORDS, 1'b0, 1'b0, pc);
    ctrl.halt_if <= 1'b1;
    id_ready     <= 1'b1;
    repeat (HALT_CYCLES) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("if_valid_o", 1'b0, if_valid);
      check_bit("instr_valid", 1'b0, if_id_pipe.instr_valid);
    end
    // Next word waits at the buffer head
    check_addr("pc_if_o", pc, pc_if);
    ctrl.halt_if <= 1'b0;
    collect(pc, SHORT_WORDS, 1'b0, 1'b0);
  endtask

  ////////////////////
  // Monitors
  ////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, stream stopped, %0d errors", cycle_cnt, error_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Busy must track every granted fetch until its answer
  always @(posedge clk) begin
    if (!rst_n) begin
      bus_pending <= 0;
    end else begin
      bus_pending <= bus_pending + int'(bus_req.req && gnt) - int'(bus_resp.rvalid);
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      check_bit("if_busy_o", bus_pending != 0, if_busy);
    end
  end

  initial begin
    clk                   = 1'b0;
    rst_n                 = 1'b0;
    ctrl                  = '0;
    trigger_match         = 1'b0;
    id_ready              = 1'b0;
    stall_en              = 1'b0;
    // Unaligned sources check the word alignment
    targets.boot_addr     = 32'h0000_1002;
    targets.jump_target   = 32'h0000_2404;
    targets.branch_target = 32'h0000_3009;
    targets.mepc          = 32'h0000_4106;
    targets.mtvec_addr    = 25'h00_0050;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_reset_state();
    test_boot();
    test_redirects();
    test_backpressure();
    test_stalls();
    test_errors();
    test_halt();
    $display("Run complete after %0d cycles, %0d errors", cycle_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verif/if_tb_memory.sv
// Instruction memory model
`timescale 1ns/1ps

module if_tb_memory (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall_en_i,
  input  if_pkg::instr_bus_req_t  bus_req_i,
  output logic                    gnt_o,
  output if_pkg::instr_bus_resp_t bus_resp_o
);

  logic [31:0]             lfsr_q = 32'h322a;
  logic                    gnt_q;
  logic                    gnt_next;
  if_pkg::instr_bus_resp_t resp_q;
  // Fetch granted at the coming rising edge
  logic                    pend_q;
  logic [if_pkg::XLEN-1:0] pend_addr_q;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // Word at an address is its bits 31:2 followed by bits 3:2
  function automatic if_pkg::instr_bus_resp_t answer(input logic [if_pkg::XLEN-1:0] addr);
    if_pkg::instr_bus_resp_t r;
    r.rvalid = 1'b1;
    r.rdata  = {addr[31:2], addr[3:2]};
    // Top nibble E is the error region
    r.err    = (addr[31:28] == 4'hE);
    return r;
  endfunction

  always @(negedge clk) begin
    if (!rst_n) begin
      gnt_q  <= 1'b0;
      resp_q <= '0;
      pend_q <= 1'b0;
    end else begin
      // Answer one cycle after the grant
      resp_q   <= pend_q ? answer(pend_addr_q) : '0;
      gnt_next = stall_en_i ? lfsr_step() : 1'b1;
      gnt_q    <= gnt_next;
      // Request only moves on a rising edge, so the next grant is known now
      pend_q      <= bus_req_i.req && gnt_next;
      pend_addr_q <= bus_req_i.addr;
    end
  end

  // Quiet bus while in reset
  assign gnt_o      = rst_n && gnt_q;
  assign bus_resp_o = rst_n ? resp_q : '0;

endmodule

//--- hw/if_stage.sv
// Instruction fetch stage top
`timescale 1ns/1ps

module if_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  if_pkg::if_ctrl_t        ctrl_i,
  input  if_pkg::pc_targets_t     targets_i,
  input  logic                    trigger_match_i,
  input  logic                    id_ready_i,
  // Instruction bus
  input  logic                    gnt_i,
  input  if_pkg::instr_bus_resp_t bus_resp_i,
  output if_pkg::instr_bus_req_t  bus_req_o,
  // Toward decode
  output logic                    if_valid_o,
  output logic [if_pkg::XLEN-1:0] pc_if_o,
  output if_pkg::if_id_pipe_t     if_id_pipe_o,
  output logic                    if_busy_o
);

  logic                          push;
  if_pkg::fetch_entry_t          entry;
  logic [if_pkg::FIFO_CNT_W-1:0] free_cnt;
  logic                          head_valid;
  if_pkg::fetch_entry_t          head;
  logic                          pop;

  // Producer, bus side
  if_fetch_unit u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl_i     (ctrl_i),
    .targets_i  (targets_i),
    .gnt_i      (gnt_i),
    .bus_resp_i (bus_resp_i),
    .free_cnt_i (free_cnt),
    .bus_req_o  (bus_req_o),
    .push_o     (push),
    .entry_o    (entry),
    .busy_o     (if_busy_o)
  );

  // Redirect flushes buffered words
  if_instr_fifo u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (ctrl_i.pc_set),
    .push_i       (push),
    .entry_i      (entry),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .free_cnt_o   (free_cnt)
  );

  // Consumer, decode side
  if_id_register u_if_id (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_i          (ctrl_i),
    .head_valid_i    (head_valid),
    .head_i          (head),
    .trigger_match_i (trigger_match_i),
    .id_ready_i      (id_ready_i),
    .pop_o           (pop),
    .if_valid_o      (if_valid_o),
    .pc_if_o         (pc_if_o),
    .if_id_pipe_o    (if_id_pipe_o)
  );

endmodule

//--- hw/if_id_register.sv
// IF/ID pipeline register
`timescale 1ns/1ps

module if_id_register (
  input  logic                    clk,
  input  logic                    rst_n,
  input  if_pkg::if_ctrl_t        ctrl_i,
  input  logic                    head_valid_i,
  input  if_pkg::fetch_entry_t    head_i,
  input  logic                    trigger_match_i,
  input  logic                    id_ready_i,
  output logic                    pop_o,
  output logic                    if_valid_o,
  output logic [if_pkg::XLEN-1:0] pc_if_o,
  output if_pkg::if_id_pipe_t     if_id_pipe_o
);

  logic                instr_valid_q;
  logic                transfer;
  if_pkg::if_id_pipe_t pipe_n;
  if_pkg::if_id_pipe_t pipe_q;

  ////////////////////
  // Handshake
  ////////////////////

  // Halt or kill hides the head from decode
  assign if_valid_o = head_valid_i && !ctrl_i.halt_if && !ctrl_i.kill_if;
  assign transfer   = if_valid_o && id_ready_i;
  // Kill drains the buffer one entry per cycle
  assign pop_o      = head_valid_i && (ctrl_i.kill_if || transfer);
  assign pc_if_o    = head_i.pc;

  ////////////////////
  // Metadata
  ////////////////////

  always_comb begin
    pipe_n             = '0;
    pipe_n.instr_valid = 1'b1;
    pipe_n.instr       = head_i.rdata;
    pipe_n.pc          = head_i.pc;
    pipe_n.bus_err     = head_i.err;
    // Low bits 2'b11 mark a full-size instruction
    pipe_n.compressed  = ~&head_i.rdata[1:0];
    // Known to fault later in the pipe
    pipe_n.abort_op    = head_i.err || trigger_match_i;
  end

  // Valid bit follows decode ready and holds while stalled
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
    end else if (id_ready_i) begin
      instr_valid_q <= if_valid_o;
    end
  end

  always_ff @(posedge clk) begin
    if (transfer) begin
      pipe_q <= pipe_n;
    end
  end

  always_comb begin
    if_id_pipe_o             = pipe_q;
    if_id_pipe_o.instr_valid = instr_valid_q;
  end

  a_no_valid_on_kill: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.kill_if |-> !if_valid_o);

endmodule

//--- hw/if_instr_fifo.sv
// Fetch buffer
`timescale 1ns/1ps

module if_instr_fifo (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic                          push_i,
  input  if_pkg::fetch_entry_t          entry_i,
  input  logic                          pop_i,
  output logic                          head_valid_o,
  output if_pkg::fetch_entry_t          head_o,
  output logic [if_pkg::FIFO_CNT_W-1:0] free_cnt_o
);

  if_pkg::fetch_entry_t          mem_q [if_pkg::FIFO_DEPTH];
  logic [if_pkg::FIFO_CNT_W-1:0] wr_ptr_q;
  logic [if_pkg::FIFO_CNT_W-1:0] rd_ptr_q;
  logic [if_pkg::FIFO_CNT_W-1:0] count_q;

  // Pointer step with wrap at the last entry
  function automatic logic [if_pkg::FIFO_CNT_W-1:0] ptr_inc(
    input logic [if_pkg::FIFO_CNT_W-1:0] ptr
  );
    return (ptr == if_pkg::FIFO_DEPTH - 1'b1) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Redirect empties the buffer, a same-cycle push is lost
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && pop_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];
  assign free_cnt_o   = if_pkg::FIFO_DEPTH - count_q;

  // Fetch unit throttling must keep the buffer from overflowing
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && !flush_i) |-> (count_q != if_pkg::FIFO_DEPTH));

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> head_valid_o);

endmodule

//--- hw/if_fetch_unit.sv
// Fetch unit
`timescale 1ns/1ps

module if_fetch_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  if_pkg::if_ctrl_t              ctrl_i,
  input  if_pkg::pc_targets_t           targets_i,
  input  logic                          gnt_i,
  input  if_pkg::instr_bus_resp_t       bus_resp_i,
  input  logic [if_pkg::FIFO_CNT_W-1:0] free_cnt_i,
  output if_pkg::instr_bus_req_t        bus_req_o,
  output logic                          push_o,
  output if_pkg::fetch_entry_t          entry_o,
  output logic                          busy_o
);

  logic [if_pkg::XLEN-1:0]       redirect_addr;
  logic [if_pkg::XLEN-1:0]       pc_q;
  logic                          fetch_en_q;
  logic                          req;
  logic                          grant;
  logic [if_pkg::FIFO_CNT_W-1:0] out_cnt_q;
  logic [if_pkg::FIFO_CNT_W-1:0] out_cnt_n;
  logic [if_pkg::FIFO_CNT_W-1:0] disc_cnt_q;
  // Addresses of granted fetches, oldest at the read pointer
  logic [if_pkg::XLEN-1:0]       addr_q [if_pkg::MAX_OUTSTANDING];
  logic                          aq_wr_ptr_q;
  logic                          aq_rd_ptr_q;

  ////////////////////
  // Next PC
  ////////////////////

  always_comb begin
    // Boot as fallback
    redirect_addr = {targets_i.boot_addr[if_pkg::XLEN-1:2], 2'b00};
    case (ctrl_i.pc_mux)
      if_pkg::PC_BOOT:     redirect_addr = {targets_i.boot_addr[if_pkg::XLEN-1:2], 2'b00};
      if_pkg::PC_JUMP:     redirect_addr = {targets_i.jump_target[if_pkg::XLEN-1:2], 2'b00};
      if_pkg::PC_BRANCH:   redirect_addr = {targets_i.branch_target[if_pkg::XLEN-1:2], 2'b00};
      // Return to the saved exception PC
      if_pkg::PC_MRET:     redirect_addr = {targets_i.mepc[if_pkg::XLEN-1:2], 2'b00};
      // All exceptions share the trap base
      if_pkg::PC_TRAP_EXC: redirect_addr = {targets_i.mtvec_addr, 7'h00};
      // Vectored interrupts, base plus index times 4
      if_pkg::PC_TRAP_IRQ: redirect_addr = {targets_i.mtvec_addr, ctrl_i.mtvec_index, 2'b00};
      default: ;
    endcase
  end

  ////////////////////
  // Request issue
  ////////////////////

  // Room on the bus and room in the buffer for every answer in flight
  assign req   = fetch_en_q && (out_cnt_q < if_pkg::MAX_OUTSTANDING) && (out_cnt_q < free_cnt_i);
  assign grant = req && gnt_i;

  assign bus_req_o.req  = req;
  assign bus_req_o.addr = pc_q;

  // Outstanding count after this edge
  always_comb begin
    out_cnt_n = out_cnt_q;
    if (grant && !bus_resp_i.rvalid) begin
      out_cnt_n = out_cnt_q + 1'b1;
    end else if (!grant && bus_resp_i.rvalid) begin
      out_cnt_n = out_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pc_q        <= '0;
      fetch_en_q  <= 1'b0;
      out_cnt_q   <= '0;
      disc_cnt_q  <= '0;
      aq_wr_ptr_q <= 1'b0;
      aq_rd_ptr_q <= 1'b0;
    end else begin
      out_cnt_q <= out_cnt_n;
      // Two-entry queue, pointers wrap on overflow
      if (grant) begin
        aq_wr_ptr_q <= aq_wr_ptr_q + 1'b1;
      end
      if (bus_resp_i.rvalid) begin
        aq_rd_ptr_q <= aq_rd_ptr_q + 1'b1;
      end
      if (ctrl_i.pc_set) begin
        pc_q       <= redirect_addr;
        fetch_en_q <= 1'b1;
        // Everything still in flight after this edge belongs to the old stream
        disc_cnt_q <= out_cnt_n;
      end else begin
        if (grant) begin
          pc_q <= pc_q + 32'd4;
        end
        if (bus_resp_i.rvalid && (disc_cnt_q != '0)) begin
          disc_cnt_q <= disc_cnt_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      addr_q[aq_wr_ptr_q] <= pc_q;
    end
  end

  ////////////////////
  // Response filter
  ////////////////////

  // Old-stream answers are dropped
  assign push_o        = bus_resp_i.rvalid && (disc_cnt_q == '0) && !ctrl_i.pc_set;
  assign entry_o.pc    = addr_q[aq_rd_ptr_q];
  assign entry_o.rdata = bus_resp_i.rdata;
  assign entry_o.err   = bus_resp_i.err;

  assign busy_o = (out_cnt_q != '0);

  a_out_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= if_pkg::MAX_OUTSTANDING);

  // Bus must not answer a fetch that was never granted
  a_rvalid_pending: assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_i.rvalid |-> (out_cnt_q != '0));

endmodule

//--- hw/if_pkg.sv
// Instruction fetch stage
// Shared constants and types
package if_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned XLEN = 32;
  // Counter wide enough for 0 up to the buffer depth
  localparam int unsigned FIFO_CNT_W = 2;
  // Two in flight plus one held by decode
  localparam logic [FIFO_CNT_W-1:0] FIFO_DEPTH = 2'd3;
  localparam logic [FIFO_CNT_W-1:0] MAX_OUTSTANDING = 2'd2;
  // Trap base is this field followed by seven zero bits
  localparam int unsigned MTVEC_ADDR_W = 25;
  localparam int unsigned MTVEC_IDX_W = 5;

  ////////////////////
  // PC mux
  ////////////////////

  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  ////////////////////
  // Structs
  ////////////////////

  // Controller command to the stage
  typedef struct packed {
    logic                   pc_set;
    pc_mux_e                pc_mux;
    logic [MTVEC_IDX_W-1:0] mtvec_index;
    logic                   halt_if;
    logic                   kill_if;
    logic                   spare;
  } if_ctrl_t;

  // Redirect sources
  typedef struct packed {
    logic [XLEN-1:0]         boot_addr;
    logic [XLEN-1:0]         jump_target;
    logic [XLEN-1:0]         branch_target;
    logic [XLEN-1:0]         mepc;
    logic [MTVEC_ADDR_W-1:0] mtvec_addr;
  } pc_targets_t;

  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
  } instr_bus_req_t;

  typedef struct packed {
    logic            rvalid;
    logic [XLEN-1:0] rdata;
    logic            err;
  } instr_bus_resp_t;

  // One buffered fetch with its address
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rdata;
    logic            err;
  } fetch_entry_t;

  typedef struct packed {
    logic            instr_valid;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic            bus_err;
    logic            compressed;
    logic            abort_op;
  } if_id_pipe_t;

endpackage
